// File: list.f
hw/ex_pkg.sv
hw/ex_decoder.sv
hw/alu.sv
hw/mdu.sv
hw/ex_result.sv
hw/ex_unit.sv
bench/ex_unit_asserts.sv
bench/tb_ex_unit.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_unit
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '^$(PASS_MSG)$$' $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_ex_unit.sv
`timescale 1ns/1ps

module tb_ex_unit import ex_pkg::*; ();

    localparam int N_RAND = 6; // Random operand pairs per operation
    localparam int N_EDGE = 9; // All pairs of the three edge values
    localparam int NUM_INSTR = 18 * (N_RAND + N_EDGE) + 10 * N_RAND + 8;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + 100;
    localparam logic [31:0] EDGE [3] = '{32'h0000_0000, 32'h8000_0000, 32'hffff_ffff};

    logic            clk;
    logic            rst_n;
    logic            issue;
    logic [1:0]      ex_op;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] result;
    logic            result_valid;
    logic            illegal;
    logic            busy;

    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state = 32'd72023;

    ex_unit UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .ex_op        (ex_op),
        .funct3       (funct3),
        .funct7       (funct7),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .result       (result),
        .result_valid (result_valid),
        .illegal      (illegal),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected {illegal, result} from the RV32IM rules
    function automatic logic [32:0] model(input logic [1:0] op, input logic [2:0] f3,
                                          input logic [6:0] f7, input logic [31:0] a,
                                          input logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [31:0] r;
        logic        bad;
        logic        ovf;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff); // Signed overflow
        r   = '0;
        bad = 1'b0;
        if (op == EXOP_RTYPE && f7 == F7_MULDIV) begin
            case (f3)
                3'd0: r = a * b;
                3'd1: r = 32'((sa * sb) >> 32);
                3'd2: r = 32'((sa * {32'd0, b}) >> 32);
                3'd3: r = 32'(({32'd0, a} * {32'd0, b}) >> 32);
                3'd4: r = (b == 0) ? '1 : ovf ? a : 32'($signed(a) / $signed(b));
                3'd5: r = (b == 0) ? '1 : a / b;
                3'd6: r = (b == 0) ? a : ovf ? '0 : 32'($signed(a) % $signed(b));
                default: r = (b == 0) ? a : a % b;
            endcase
        end else if (op == EXOP_ADDR) begin
            r = a + b;
        end else if (op == EXOP_ITYPE || (op == EXOP_RTYPE && f7 inside {F7_BASE, F7_ALT})) begin
            case (f3)
                3'd0: r = (op == EXOP_RTYPE && f7 == F7_ALT) ? a - b : a + b;
                3'd1: r = a << b[4:0];
                3'd2: r = {31'd0, $signed(a) < $signed(b)};
                3'd3: r = {31'd0, a < b};
                3'd4: r = a ^ b;
                3'd5: r = (f7 == F7_ALT) ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: r = a | b;
                default: r = a & b;
            endcase
            if (op == EXOP_ITYPE)
                bad = (f3 == 3'd1 && f7 != F7_BASE) ||
                      (f3 == 3'd5 && !(f7 inside {F7_BASE, F7_ALT}));
            else
                bad = (f7 == F7_ALT) && !(f3 inside {3'd0, 3'd5});
        end else begin
            bad = 1'b1; // Class 11 or unknown funct7
        end
        return {bad, bad ? 32'd0 : r};
    endfunction

    function automatic int latency(input logic [1:0] op, input logic [2:0] f3,
                                   input logic [6:0] f7, input logic [31:0] b);
        if (op != EXOP_RTYPE || f7 != F7_MULDIV) return 1;
        if (!f3[2] || b == 0) return 2; // MUL family or zero divisor
        return DIV_STEPS + 2;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("Error: %s expected %h, got %h", name, exp, got);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("%s", what);
    endtask

    // Ends at the negedge after edge 0, t0 marks that cycle
    task automatic send(input logic [1:0] op, input logic [2:0] f3, input logic [6:0] f7,
                        input logic [31:0] a, input logic [31:0] b, output int t0);
        @(posedge clk);
        issue     <= 1'b1;
        ex_op     <= op;
        funct3    <= f3;
        funct7    <= f7;
        operand_a <= a;
        operand_b <= b;
        @(posedge clk);
        issue <= 1'b0;
        @(negedge clk);
        t0 = cycle_count;
    endtask

    task automatic await_check(input logic [1:0] op, input logic [2:0] f3, input logic [6:0] f7,
                               input logic [31:0] a, input logic [31:0] b, input int t0);
        logic [32:0] exp;
        int          lat;
        int          want;
        exp  = model(op, f3, f7, a, b);
        want = latency(op, f3, f7, b);
        while (!result_valid) begin
            assert (busy) else report_problem("busy went low before result_valid");
            @(negedge clk);
        end
        lat = cycle_count - t0;
        checks++;
        assert (result === exp[31:0]) else report_mismatch("result", exp[31:0], result);
        assert (illegal === exp[32]) else report_mismatch("illegal", 32'(exp[32]), 32'(illegal));
        assert (lat == want)
            else report_problem($sformatf("result_valid came %0d cycles after issue, not %0d",
                                          lat, want));
        assert (!busy) else report_problem("busy still high while result_valid is high");
    endtask

    task automatic exec(input logic [1:0] op, input logic [2:0] f3, input logic [6:0] f7,
                        input logic [31:0] a, input logic [31:0] b);
        int t0;
        send(op, f3, f7, a, b, t0);
        await_check(op, f3, f7, a, b, t0);
    endtask

    // Random operands first, then every pair of edge values
    task automatic sweep(input logic [1:0] op, input logic [2:0] f3, input logic [6:0] f7);
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < N_RAND; i++) begin
            a = next_rand();
            b = next_rand();
            if (i % 2 == 1) b = b >> 20; // Small divisors
            exec(op, f3, f7, a, b);
        end
        for (int i = 0; i < N_EDGE; i++) exec(op, f3, f7, EDGE[i / 3], EDGE[i % 3]);
    endtask

    task automatic test_alu_rtype();
        for (int k = 0; k < 10; k++) begin
            if (k < 8) sweep(EXOP_RTYPE, 3'(k), F7_BASE);
            else sweep(EXOP_RTYPE, (k == 8) ? 3'd0 : 3'd5, F7_ALT); // SUB and SRA
        end
    endtask

    task automatic test_itype();
        logic [2:0]  f3;
        logic [31:0] imm;
        logic [31:0] b;
        for (int k = 0; k < 9; k++) begin
            f3 = (k < 8) ? 3'(k) : 3'd5; // Last pass is SRAI
            for (int i = 0; i < N_RAND; i++) begin
                imm = next_rand();
                if (f3 == 3'd1 || f3 == 3'd5) b = {20'd0, (k == 8) ? F7_ALT : F7_BASE, imm[4:0]};
                else b = {{20{imm[11]}}, imm[11:0]};
                exec(EXOP_ITYPE, f3, b[11:5], next_rand(), b);
            end
        end
        for (int i = 0; i < N_RAND; i++)
            exec(EXOP_ADDR, 3'(next_rand()), 7'(next_rand()), next_rand(), next_rand());
    endtask

    task automatic test_mdu();
        for (int k = 0; k < 8; k++) sweep(EXOP_RTYPE, 3'(k), F7_MULDIV);
    endtask

    task automatic test_illegal();
        exec(2'b11, 3'd0, F7_BASE, next_rand(), next_rand());
        exec(EXOP_ITYPE, 3'd1, F7_ALT, next_rand(), {20'd0, F7_ALT, 5'd3});
        exec(EXOP_ITYPE, 3'd5, F7_MULDIV, next_rand(), {20'd0, F7_MULDIV, 5'd4});
        exec(EXOP_RTYPE, 3'd0, 7'b0000010, next_rand(), next_rand());
        exec(EXOP_RTYPE, 3'd1, F7_ALT, next_rand(), next_rand());
        exec(EXOP_RTYPE, 3'd7, F7_ALT, next_rand(), next_rand());
    endtask

    // A stray issue in the middle of a divide must vanish
    task automatic test_dropped_issue();
        int t0;
        send(EXOP_RTYPE, MDU_DIV, F7_MULDIV, 32'hffff_fc18, 32'd7, t0);
        repeat (4) @(posedge clk);
        issue     <= 1'b1;
        ex_op     <= EXOP_RTYPE;
        funct3    <= 3'd0;
        funct7    <= F7_BASE;
        operand_a <= 32'd1;
        operand_b <= 32'd2;
        @(posedge clk);
        issue <= 1'b0;
        @(negedge clk);
        await_check(EXOP_RTYPE, MDU_DIV, F7_MULDIV, 32'hffff_fc18, 32'd7, t0);
        repeat (3) begin
            @(negedge clk);
            assert (!result_valid) else report_problem("a result came from a dropped issue");
        end
        exec(EXOP_RTYPE, 3'd0, F7_ALT, 32'd50, 32'd8);
    endtask

    initial begin
        rst_n     = 1'b0;
        issue     = 1'b0;
        ex_op     = '0;
        funct3    = '0;
        funct7    = '0;
        operand_a = '0;
        operand_b = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!result_valid && !illegal && !busy && result == '0)
            else report_problem("outputs not cleared by reset");
        test_alu_rtype();
        test_itype();
        test_mdu();
        test_illegal();
        test_dropped_issue();
        repeat (2) @(posedge clk);
        $display("Errors: %0d in %0d checked instructions", errors, checks);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: bench/ex_unit_asserts.sv
`timescale 1ns/1ps

module ex_unit_asserts import ex_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic issue,
    input logic busy,
    input logic result_valid
);

    logic pending;
    int   wait_cnt; // Cycles since the last accepted issue

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= 1'b0;
            wait_cnt <= 0;
        end else if (issue && !busy) begin
            pending  <= 1'b1;
            wait_cnt <= 0;
        end else if (pending) begin
            if (result_valid) pending <= 1'b0;
            else wait_cnt <= wait_cnt + 1;
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else $error("result_valid high for two cycles in a row");

    a_busy_release: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && !issue) |=> !busy)
        else $error("busy still high in the cycle after result_valid");

    a_max_latency: assert property (@(posedge clk) disable iff (!rst_n)
        pending |-> (wait_cnt <= DIV_STEPS + 3))
        else $error("no result_valid within DIV_STEPS plus 3 cycles of an issue");

endmodule

bind ex_unit ex_unit_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (issue),
    .busy         (busy),
    .result_valid (result_valid)
);

// File: hw/ex_unit.sv
`timescale 1ns/1ps

module ex_unit import ex_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue,
    input  logic [1:0]      ex_op,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [XLEN-1:0] operand_a,
    input  logic [XLEN-1:0] operand_b,
    output logic [XLEN-1:0] result,
    output logic            result_valid,
    output logic            illegal,
    output logic            busy
);

    logic            start;
    logic            mdu_start;
    logic [1:0]      unit_sel;
    ex_func_u        func;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            dec_illegal;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mdu_result;
    logic            mdu_done;

    ex_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .ex_op     (ex_op),
        .funct3    (funct3),
        .funct7    (funct7),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .busy      (busy),
        .start     (start),
        .mdu_start (mdu_start),
        .unit_sel  (unit_sel),
        .func      (func),
        .op_a      (op_a),
        .op_b      (op_b),
        .illegal   (dec_illegal)
    );

    alu u_alu (
        .func       (func),
        .op_a       (op_a),
        .op_b       (op_b),
        .alu_result (alu_result)
    );

    mdu u_mdu (
        .clk        (clk),
        .rst_n      (rst_n),
        .mdu_start  (mdu_start),
        .func       (func),
        .op_a       (op_a),
        .op_b       (op_b),
        .mdu_result (mdu_result),
        .mdu_done   (mdu_done)
    );

    ex_result u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .unit_sel     (unit_sel),
        .illegal      (dec_illegal),
        .alu_result   (alu_result),
        .mdu_result   (mdu_result),
        .mdu_done     (mdu_done),
        .result       (result),
        .result_valid (result_valid),
        .illegal_out  (illegal),
        .busy         (busy)
    );

endmodule

// File: hw/ex_result.sv
`timescale 1ns/1ps

module ex_result import ex_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic [1:0]      unit_sel,
    input  logic            illegal,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] mdu_result,
    input  logic            mdu_done,
    output logic [XLEN-1:0] result,
    output logic            result_valid,
    output logic            illegal_out,
    output logic            busy
);

    logic       alu_take;
    logic       mdu_take;
    logic       pend_q;
    logic [1:0] pend_unit;

    // ALU and illegal results finish in the start cycle
    assign alu_take = start && (illegal || unit_sel != UNIT_MDU);
    assign mdu_take = mdu_done && pend_q && (pend_unit == UNIT_MDU);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
            illegal_out  <= 1'b0;
            pend_q       <= 1'b0;
            pend_unit    <= UNIT_ALU;
        end else begin
            result_valid <= alu_take | mdu_take;
            if (alu_take) begin
                result      <= illegal ? '0 : alu_result;
                illegal_out <= illegal;
            end else if (mdu_take) begin
                result      <= mdu_result;
                illegal_out <= 1'b0;
            end
            if (start && !alu_take) begin
                pend_q    <= 1'b1;  // Wait for the MDU
                pend_unit <= unit_sel;
            end else if (mdu_take) begin
                pend_q <= 1'b0;
            end
        end
    end

    assign busy = start | pend_q;

endmodule

// File: hw/mdu.sv
`timescale 1ns/1ps

module mdu import ex_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mdu_start,
    input  ex_func_u        func,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output logic [XLEN-1:0] mdu_result,
    output logic            mdu_done
);

    logic [2:0] op;
    logic       is_div;
    logic       is_rem;
    logic       div_signed;
    logic       div_by_zero;

    // Multiplier signals
    logic                 a_mul_signed;
    logic                 b_mul_signed;
    logic signed [XLEN:0] mul_a;
    logic signed [XLEN:0] mul_b;
    logic signed [2*XLEN+1:0] product;
    logic [XLEN-1:0]      mul_word;

    // Divider signals
    logic            a_neg;
    logic            b_neg;
    logic [XLEN-1:0] abs_a;
    logic [XLEN-1:0] abs_b;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] rem_in;
    logic [XLEN-1:0] quo_in;
    logic [XLEN:0]   shifted;
    logic [XLEN+1:0] trial;
    logic [XLEN-1:0] rem_nx;
    logic [XLEN-1:0] quo_nx;
    logic            div_run;
    logic            div_fix;
    logic [$clog2(DIV_STEPS)-1:0] div_cnt;

    assign op          = func.mdu.op;
    assign is_div      = op[2];
    assign is_rem      = op[1];                 // REM and REMU
    assign div_signed  = (op == MDU_DIV) || (op == MDU_REM);
    assign div_by_zero = (op_b == '0);

    assign a_mul_signed = (op == MDU_MULH) || (op == MDU_MULHSU);
    assign b_mul_signed = (op == MDU_MULH);
    assign mul_a    = {a_mul_signed & op_a[XLEN-1], op_a};
    assign mul_b    = {b_mul_signed & op_b[XLEN-1], op_b};
    assign product  = mul_a * mul_b;
    assign mul_word = (op == MDU_MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

    // Divider works on magnitudes, signs fixed at the end
    assign a_neg = div_signed & op_a[XLEN-1];
    assign b_neg = div_signed & op_b[XLEN-1];
    assign abs_a = a_neg ? -op_a : op_a;
    assign abs_b = b_neg ? -op_b : op_b;

    // One restoring step, the first one runs in the start cycle
    assign rem_in  = mdu_start ? '0 : rem_q;
    assign quo_in  = mdu_start ? abs_a : quo_q;
    assign shifted = {rem_in, quo_in[XLEN-1]};
    assign trial   = {1'b0, shifted} - {2'b00, abs_b};
    assign rem_nx  = trial[XLEN+1] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
    assign quo_nx  = {quo_in[XLEN-2:0], ~trial[XLEN+1]}; // Borrow means restore

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mdu_done <= 1'b0;
            div_run  <= 1'b0;
            div_fix  <= 1'b0;
            div_cnt  <= '0;
        end else begin
            mdu_done <= 1'b0;
            if (mdu_start) begin
                if (!is_div || div_by_zero) begin
                    mdu_done <= 1'b1; // Product or zero-divisor result
                end else begin
                    div_run <= 1'b1;
                    div_cnt <= 1;
                end
            end else if (div_run) begin
                div_cnt <= div_cnt + 1'b1;
                if (div_cnt == DIV_STEPS - 1) begin
                    div_run <= 1'b0;
                    div_fix <= 1'b1;
                end
            end else if (div_fix) begin
                div_fix  <= 1'b0;
                mdu_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mdu_start || div_run) begin
            rem_q <= rem_nx;
            quo_q <= quo_nx;
        end
        if (mdu_start) begin
            if (!is_div) mdu_result <= mul_word;
            else if (div_by_zero) mdu_result <= is_rem ? op_a : '1;
        end else if (div_fix) begin
            if (is_rem) mdu_result <= a_neg ? -rem_q : rem_q;           // Sign of dividend
            else mdu_result <= (a_neg ^ b_neg) ? -quo_q : quo_q;
        end
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu import ex_pkg::*; (
    input  ex_func_u        func,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output logic [XLEN-1:0] alu_result
);

    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;

    assign shamt = op_b[4:0];

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // Compare results for SLT and SLTU
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (func.alu)
            ALU_ADD: alu_result = sum;
            ALU_SUB: alu_result = diff;
            ALU_SLL: alu_result = op_a << shamt;
            ALU_SLT: begin
                alu_result = '0;
                alu_result[0] = lt_signed;
            end
            ALU_SLTU: begin
                alu_result = '0;
                alu_result[0] = lt_unsigned;
            end
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SRL: alu_result = op_a >> shamt;
            ALU_SRA: alu_result = $unsigned($signed(op_a) >>> shamt); // Sign fill
            ALU_OR:  alu_result = op_a | op_b;
            ALU_AND: alu_result = op_a & op_b;
            default: alu_result = '0; // Codes the decoder never produces
        endcase
    end

endmodule

// File: hw/ex_decoder.sv
`timescale 1ns/1ps

module ex_decoder import ex_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue,
    input  logic [1:0]      ex_op,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [XLEN-1:0] operand_a,
    input  logic [XLEN-1:0] operand_b,
    input  logic            busy,
    output logic            start,
    output logic            mdu_start,
    output logic [1:0]      unit_sel,
    output ex_func_u        func,
    output logic [XLEN-1:0] op_a,
    output logic [XLEN-1:0] op_b,
    output logic            illegal
);

    logic     accept;
    logic [1:0] dec_unit;
    ex_func_u dec_func;
    logic     dec_illegal;

    assign accept = issue & ~busy; // Issue during busy is dropped

    always_comb begin
        dec_unit    = UNIT_ALU;
        dec_func    = '0;
        dec_func.alu = ALU_ADD;
        dec_illegal = 1'b0;
        case (ex_op)
            EXOP_ADDR: dec_func.alu = ALU_ADD; // Address generation only adds
            EXOP_ITYPE: begin
                case (funct3)
                    3'b000: dec_func.alu = ALU_ADD;
                    3'b010: dec_func.alu = ALU_SLT;
                    3'b011: dec_func.alu = ALU_SLTU;
                    3'b100: dec_func.alu = ALU_XOR;
                    3'b110: dec_func.alu = ALU_OR;
                    3'b111: dec_func.alu = ALU_AND;
                    3'b001: begin // SLLI, upper immediate must be zero
                        if (funct7 == F7_BASE) dec_func.alu = ALU_SLL;
                        else dec_illegal = 1'b1;
                    end
                    default: begin // 101, SRLI or SRAI
                        if (funct7 == F7_BASE) dec_func.alu = ALU_SRL;
                        else if (funct7 == F7_ALT) dec_func.alu = ALU_SRA;
                        else dec_illegal = 1'b1;
                    end
                endcase
            end
            EXOP_RTYPE: begin
                case (funct7)
                    F7_BASE: begin
                        case (funct3)
                            3'b000:  dec_func.alu = ALU_ADD;
                            3'b001:  dec_func.alu = ALU_SLL;
                            3'b010:  dec_func.alu = ALU_SLT;
                            3'b011:  dec_func.alu = ALU_SLTU;
                            3'b100:  dec_func.alu = ALU_XOR;
                            3'b101:  dec_func.alu = ALU_SRL;
                            3'b110:  dec_func.alu = ALU_OR;
                            default: dec_func.alu = ALU_AND;
                        endcase
                    end
                    F7_MULDIV: begin
                        dec_unit           = UNIT_MDU;
                        dec_func.mdu.spare = 2'b00;
                        dec_func.mdu.op    = funct3; // MDU codes follow funct3
                    end
                    F7_ALT: begin
                        if (funct3 == 3'b000) dec_func.alu = ALU_SUB;
                        else if (funct3 == 3'b101) dec_func.alu = ALU_SRA;
                        else dec_illegal = 1'b1;
                    end
                    default: dec_illegal = 1'b1;
                endcase
            end
            default: dec_illegal = 1'b1; // Class 11 would have gone to the FPU
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start     <= 1'b0;
            mdu_start <= 1'b0;
            unit_sel  <= UNIT_ALU;
            func      <= '0;
            illegal   <= 1'b0;
        end else begin
            start     <= accept;
            mdu_start <= accept && (dec_unit == UNIT_MDU) && !dec_illegal;
            if (accept) begin
                unit_sel <= dec_unit;
                func     <= dec_func;
                illegal  <= dec_illegal;
            end
        end
    end

    // Operands held until the next accepted issue
    always_ff @(posedge clk) begin
        if (accept) begin
            op_a <= operand_a;
            op_b <= operand_b;
        end
    end

endmodule

// File: hw/ex_pkg.sv
package ex_pkg;

    // Datapath width and divider iteration count
    localparam int XLEN      = 32;
    localparam int DIV_STEPS = 32;

    // Unit select, BMU and FPU are reserved in this stage
    localparam logic [1:0] UNIT_ALU = 2'b00;
    localparam logic [1:0] UNIT_MDU = 2'b01;
    localparam logic [1:0] UNIT_BMU = 2'b10;
    localparam logic [1:0] UNIT_FPU = 2'b11;

    // Instruction class from the main decoder
    localparam logic [1:0] EXOP_ADDR  = 2'b00; // Load, store, branch, AUIPC, JAL, JALR
    localparam logic [1:0] EXOP_ITYPE = 2'b01;
    localparam logic [1:0] EXOP_RTYPE = 2'b10;

    // ALU operation codes
    localparam logic [4:0] ALU_ADD  = 5'b00000;
    localparam logic [4:0] ALU_SUB  = 5'b00010;
    localparam logic [4:0] ALU_SLL  = 5'b00100;
    localparam logic [4:0] ALU_SLT  = 5'b01000;
    localparam logic [4:0] ALU_SLTU = 5'b01100;
    localparam logic [4:0] ALU_XOR  = 5'b10000;
    localparam logic [4:0] ALU_SRL  = 5'b10100;
    localparam logic [4:0] ALU_SRA  = 5'b10110;
    localparam logic [4:0] ALU_OR   = 5'b11000;
    localparam logic [4:0] ALU_AND  = 5'b11100;

    // MDU operation codes, same as funct3 of the M extension
    localparam logic [2:0] MDU_MUL    = 3'b000;
    localparam logic [2:0] MDU_MULH   = 3'b001;
    localparam logic [2:0] MDU_MULHSU = 3'b010;
    localparam logic [2:0] MDU_MULHU  = 3'b011;
    localparam logic [2:0] MDU_DIV    = 3'b100;
    localparam logic [2:0] MDU_DIVU   = 3'b101;
    localparam logic [2:0] MDU_REM    = 3'b110;
    localparam logic [2:0] MDU_REMU   = 3'b111;

    // funct7 values that select the operation group
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB, SRA, SRAI
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef struct packed {
        logic [1:0] spare;
        logic [2:0] op;
    } mdu_func_t;

    // Operation word, meaning depends on the unit select
    typedef union packed {
        logic [4:0] alu;
        mdu_func_t  mdu;
    } ex_func_u;

endpackage
